/* exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// data path
`define XLEN            32
`define REG_ADDR_W      5
`define SHAMT_W         5

// fetch redirect carries only the low pc bits
`define BR_ADDR_W       12

// sram word address and ram type field
`define SRAM_ADDR_W     13
`define SRAM_ADDR_RNG   12:0
`define SRAM_TYPE_RNG   14:13

// link value step
`define PC_STEP         4

`endif

/* exe_pkg.sv */
`default_nettype none

package exe_pkg;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_AUIPC,
        ALU_LINK
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_e;

    // loads first, then stores
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LD_IRAM,
        SEL_LD_WRAM,
        SEL_LD_ORAM,
        SEL_ST_IRAM,
        SEL_ST_WRAM,
        SEL_ST_ORAM
    } sram_sel_e;

endpackage

`default_nettype wire

/* int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module int_alu import exe_pkg::*; (
    input  wire [`XLEN-1:0] src1,
    input  wire [`XLEN-1:0] src2,
    input  wire [`XLEN-1:0] pc,
    input  wire alu_op_e    alu_op,
    output logic [`XLEN-1:0] result
);

    logic [`SHAMT_W-1:0] shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    assign shamt       = src2[`SHAMT_W-1:0];
    // full two's-complement order
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = src1 + src2;
            end
            ALU_SUB: begin
                result = src1 - src2;
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = src1 ^ src2;
            end
            ALU_OR: begin
                result = src1 | src2;
            end
            ALU_AND: begin
                result = src1 & src2;
            end
            ALU_SLL: begin
                result = src1 << shamt;
            end
            ALU_SRL: begin
                result = src1 >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            // immediate already shifted by the decoder
            ALU_LUI: begin
                result = src2;
            end
            ALU_AUIPC: begin
                result = pc + src2;
            end
            // return address for jal/jalr
            ALU_LINK: begin
                result = pc + `XLEN'(`PC_STEP);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module branch_unit import exe_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  fire,
    input  wire [`XLEN-1:0]      src1,
    input  wire [`XLEN-1:0]      src2,
    input  wire [`XLEN-1:0]      pc,
    input  wire [`XLEN-1:0]      imm,
    input  wire br_op_e          br_op,
    output logic                 br_vld,
    output logic [`BR_ADDR_W-1:0] br_addr,
    output logic                 is_cond
);

    logic             taken;
    logic [`XLEN-1:0] target;
    logic             eq;
    logic             lt_s;
    logic             lt_u;

    assign eq   = src1 == src2;
    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;

    assign is_cond = br_op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    // jumps always redirect
    always_comb begin
        case (br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (br_op == BR_JAL) begin
            target = pc + src2;
        end else if (br_op == BR_JALR) begin
            target = src1 + src2;
        end else if (is_cond) begin
            target = pc + imm;
        end else begin
            target = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            br_vld <= 1'b0;
        end else begin
            br_vld <= fire & taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            br_addr <= target[`BR_ADDR_W-1:0];
        end
    end

    // top blocks issue during a redirect, so no back-to-back redirects
    a_no_double_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        br_vld |=> !br_vld
    );

endmodule

`default_nettype wire

/* mem_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module mem_addr_gen import exe_pkg::*; (
    input  wire [`XLEN-1:0]         src1,
    input  wire [`XLEN-1:0]         src2,
    input  wire [`XLEN-1:0]         imm,
    input  wire mem_op_e            mem_op,
    output logic [`SRAM_ADDR_W-1:0] ld_st_addr,
    output sram_sel_e               sram_sel
);

    logic             is_ld;
    logic             is_st;
    logic [`XLEN-1:0] addr_sum;

    assign is_ld = mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    assign is_st = mem_op inside {MEM_SB, MEM_SH, MEM_SW};

    // stores take their offset from the immediate
    assign addr_sum   = is_st ? src1 + imm : src1 + src2;
    assign ld_st_addr = (is_ld | is_st) ? addr_sum[`SRAM_ADDR_RNG] : '0;

    always_comb begin
        sram_sel = SEL_NONE;
        // type field 00 iram, 10 wram, 01 oram, 11 unmapped
        case (addr_sum[`SRAM_TYPE_RNG])
            2'b00: begin
                if (is_ld) sram_sel = SEL_LD_IRAM;
                if (is_st) sram_sel = SEL_ST_IRAM;
            end
            2'b10: begin
                if (is_ld) sram_sel = SEL_LD_WRAM;
                if (is_st) sram_sel = SEL_ST_WRAM;
            end
            2'b01: begin
                if (is_ld) sram_sel = SEL_LD_ORAM;
                if (is_st) sram_sel = SEL_ST_ORAM;
            end
            default: begin
                sram_sel = SEL_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* lsu_issue_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module lsu_issue_reg import exe_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      fire,
    input  wire                      is_cond,
    input  wire                      wb_vld_in,
    input  wire                      lsu_rdy,
    input  wire mem_op_e             mem_op_in,
    input  wire [`REG_ADDR_W-1:0]    wb_addr_in,
    input  wire [`XLEN-1:0]          wb_data_in,
    input  wire [`XLEN-1:0]          src2_in,
    input  wire [`SRAM_ADDR_W-1:0]   addr_in,
    input  wire sram_sel_e           sel_in,
    output logic                     vld,
    output logic                     wb_vld,
    output mem_op_e                  mem_op,
    output logic [`REG_ADDR_W-1:0]   wb_addr,
    output logic [`XLEN-1:0]         wb_data,
    output logic [`XLEN-1:0]         src2,
    output logic [`SRAM_ADDR_W-1:0]  ld_st_addr,
    output sram_sel_e                sram_sel
);

    logic issue;

    // conditional branches have nothing for the lsu
    assign issue = fire & ~is_cond;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld    <= 1'b0;
            wb_vld <= 1'b0;
        end else begin
            vld    <= issue | (vld & ~lsu_rdy);
            wb_vld <= (issue & wb_vld_in) | (wb_vld & ~lsu_rdy);
        end
    end

    // payload only moves on fire
    always_ff @(posedge clk) begin
        if (fire) begin
            mem_op     <= mem_op_in;
            wb_addr    <= wb_addr_in;
            wb_data    <= wb_data_in;
            src2       <= src2_in;
            ld_st_addr <= addr_in;
            sram_sel   <= sel_in;
        end
    end

    // relies on the top holding fire low while the lsu stalls
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld && !lsu_rdy) |=> (vld && $stable(wb_data) && $stable(ld_st_addr))
    );

endmodule

`default_nettype wire

/* exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module exe_top import exe_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      idu_alu_vld,
    input  wire [`XLEN-1:0]          idu_alu_src1,
    input  wire [`XLEN-1:0]          idu_alu_src2,
    input  wire [`XLEN-1:0]          idu_alu_br_st_imm,
    input  wire [`XLEN-1:0]          idu_alu_pc,
    input  wire                      idu_alu_wb_vld,
    input  wire [`REG_ADDR_W-1:0]    idu_alu_wb_addr,
    input  wire alu_op_e             idu_alu_alu_op,
    input  wire br_op_e              idu_alu_br_op,
    input  wire mem_op_e             idu_alu_mem_op,
    input  wire                      lsu_alu_rdy,
    output logic                     alu_ifu_br_vld,
    output logic [`BR_ADDR_W-1:0]    alu_ifu_br_addr,
    output logic                     alu_idu_rdy,
    output logic                     alu_idu_flush_vld,
    output logic                     alu_idu_wb_vld,
    output logic [`REG_ADDR_W-1:0]   alu_idu_wb_addr,
    output logic [`XLEN-1:0]         alu_idu_wb_data,
    output logic                     alu_idu_ld_vld,
    output logic                     alu_lsu_vld,
    output logic                     alu_lsu_wb_vld,
    output mem_op_e                  alu_lsu_mem_op,
    output logic [`REG_ADDR_W-1:0]   alu_lsu_wb_addr,
    output logic [`XLEN-1:0]         alu_lsu_wb_data,
    output logic [`XLEN-1:0]         alu_lsu_src2,
    output logic [`SRAM_ADDR_W-1:0]  alu_lsu_ld_st_addr,
    output sram_sel_e                alu_lsu_sram_sel
);

    logic                    fire;
    logic                    is_cond;
    logic [`XLEN-1:0]        alu_result;
    logic [`SRAM_ADDR_W-1:0] mem_addr;
    sram_sel_e               mem_sel;

    // issue only with lsu ready and no redirect in flight
    assign fire = idu_alu_vld & lsu_alu_rdy & ~alu_ifu_br_vld;

    assign alu_idu_rdy       = lsu_alu_rdy;
    assign alu_idu_flush_vld = alu_ifu_br_vld;

    // same-cycle forwarding to the decoder
    assign alu_idu_wb_vld  = fire & idu_alu_wb_vld;
    assign alu_idu_wb_addr = idu_alu_wb_addr;
    assign alu_idu_wb_data = alu_result;
    assign alu_idu_ld_vld  = idu_alu_mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};

    int_alu u_int_alu (
        .src1   (idu_alu_src1),
        .src2   (idu_alu_src2),
        .pc     (idu_alu_pc),
        .alu_op (idu_alu_alu_op),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .fire    (fire),
        .src1    (idu_alu_src1),
        .src2    (idu_alu_src2),
        .pc      (idu_alu_pc),
        .imm     (idu_alu_br_st_imm),
        .br_op   (idu_alu_br_op),
        .br_vld  (alu_ifu_br_vld),
        .br_addr (alu_ifu_br_addr),
        .is_cond (is_cond)
    );

    mem_addr_gen u_mem_addr_gen (
        .src1       (idu_alu_src1),
        .src2       (idu_alu_src2),
        .imm        (idu_alu_br_st_imm),
        .mem_op     (idu_alu_mem_op),
        .ld_st_addr (mem_addr),
        .sram_sel   (mem_sel)
    );

    lsu_issue_reg u_lsu_issue_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .fire       (fire),
        .is_cond    (is_cond),
        .wb_vld_in  (idu_alu_wb_vld),
        .lsu_rdy    (lsu_alu_rdy),
        .mem_op_in  (idu_alu_mem_op),
        .wb_addr_in (idu_alu_wb_addr),
        .wb_data_in (alu_result),
        .src2_in    (idu_alu_src2),
        .addr_in    (mem_addr),
        .sel_in     (mem_sel),
        .vld        (alu_lsu_vld),
        .wb_vld     (alu_lsu_wb_vld),
        .mem_op     (alu_lsu_mem_op),
        .wb_addr    (alu_lsu_wb_addr),
        .wb_data    (alu_lsu_wb_data),
        .src2       (alu_lsu_src2),
        .ld_st_addr (alu_lsu_ld_st_addr),
        .sram_sel   (alu_lsu_sram_sel)
    );

endmodule

`default_nettype wire

/* tb_exe_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exe_consts.svh"

module tb_exe_top import exe_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    // 84 alu, 48 branch, 64 memory, 12 stall rounds of up to 7 cycles
    localparam int NUM_TXN    = 280;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    idu_alu_vld;
    logic [`XLEN-1:0]        idu_alu_src1;
    logic [`XLEN-1:0]        idu_alu_src2;
    logic [`XLEN-1:0]        idu_alu_br_st_imm;
    logic [`XLEN-1:0]        idu_alu_pc;
    logic                    idu_alu_wb_vld;
    logic [`REG_ADDR_W-1:0]  idu_alu_wb_addr;
    alu_op_e                 idu_alu_alu_op;
    br_op_e                  idu_alu_br_op;
    mem_op_e                 idu_alu_mem_op;
    logic                    lsu_alu_rdy;
    logic                    alu_ifu_br_vld;
    logic [`BR_ADDR_W-1:0]   alu_ifu_br_addr;
    logic                    alu_idu_rdy;
    logic                    alu_idu_flush_vld;
    logic                    alu_idu_wb_vld;
    logic [`REG_ADDR_W-1:0]  alu_idu_wb_addr;
    logic [`XLEN-1:0]        alu_idu_wb_data;
    logic                    alu_idu_ld_vld;
    logic                    alu_lsu_vld;
    logic                    alu_lsu_wb_vld;
    mem_op_e                 alu_lsu_mem_op;
    logic [`REG_ADDR_W-1:0]  alu_lsu_wb_addr;
    logic [`XLEN-1:0]        alu_lsu_wb_data;
    logic [`XLEN-1:0]        alu_lsu_src2;
    logic [`SRAM_ADDR_W-1:0] alu_lsu_ld_st_addr;
    sram_sel_e               alu_lsu_sram_sel;

    logic [31:0] lcg_state = 32'h7263_bcf4;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          flush_cnt = 0;
    int          stall_cnt = 0;
    int          redirect_cnt = 0;

    // expected state of the registered outputs
    logic                    m_br_vld;
    logic [`BR_ADDR_W-1:0]   m_br_addr;
    logic                    m_lsu_vld;
    logic                    m_lsu_wb_vld;
    mem_op_e                 m_mem_op;
    logic [`REG_ADDR_W-1:0]  m_wb_addr;
    logic [`XLEN-1:0]        m_wb_data;
    logic [`XLEN-1:0]        m_src2;
    logic [`SRAM_ADDR_W-1:0] m_addr;
    sram_sel_e               m_sel;

    exe_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic signed_lt(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        if (a[`XLEN-1] != b[`XLEN-1]) begin
            return a[`XLEN-1];
        end
        return a < b;
    endfunction

    function automatic logic [`XLEN-1:0] ref_alu(input alu_op_e op, input logic [`XLEN-1:0] s1,
                                                 input logic [`XLEN-1:0] s2,
                                                 input logic [`XLEN-1:0] pc);
        logic [`SHAMT_W-1:0] sh;
        logic [`XLEN-1:0]    r;
        sh = s2[`SHAMT_W-1:0];
        r = '0;
        case (op)
            ALU_ADD:   r = s1 + s2;
            ALU_SUB:   r = s1 - s2;
            ALU_SLT:   r = `XLEN'(signed_lt(s1, s2));
            ALU_SLTU:  r = `XLEN'(s1 < s2);
            ALU_XOR:   r = s1 ^ s2;
            ALU_OR:    r = s1 | s2;
            ALU_AND:   r = s1 & s2;
            ALU_SLL:   r = s1 << sh;
            ALU_SRL:   r = s1 >> sh;
            ALU_SRA: begin
                r = s1 >> sh;
                if (s1[`XLEN-1]) begin
                    r = r | ~({`XLEN{1'b1}} >> sh);
                end
            end
            ALU_LUI:   r = s2;
            ALU_AUIPC: r = pc + s2;
            ALU_LINK:  r = pc + `XLEN'(`PC_STEP);
            default:   r = '0;
        endcase
        return r;
    endfunction

    function automatic logic is_cond_op(input br_op_e op);
        return op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    endfunction

    function automatic logic ref_taken(input br_op_e op, input logic [`XLEN-1:0] s1,
                                       input logic [`XLEN-1:0] s2);
        case (op)
            BR_BEQ:  return s1 == s2;
            BR_BNE:  return s1 != s2;
            BR_BLT:  return signed_lt(s1, s2);
            BR_BGE:  return !signed_lt(s1, s2);
            BR_BLTU: return s1 < s2;
            BR_BGEU: return s1 >= s2;
            BR_JAL:  return 1'b1;
            BR_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] ref_target(input br_op_e op, input logic [`XLEN-1:0] s1,
                                                    input logic [`XLEN-1:0] s2,
                                                    input logic [`XLEN-1:0] pc,
                                                    input logic [`XLEN-1:0] imm);
        if (op == BR_JAL) begin
            return pc + s2;
        end
        if (op == BR_JALR) begin
            return s1 + s2;
        end
        return pc + imm;
    endfunction

    function automatic logic is_load_op(input mem_op_e op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic is_store_op(input mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic logic [`XLEN-1:0] ref_mem_sum(input mem_op_e op,
                                                     input logic [`XLEN-1:0] s1,
                                                     input logic [`XLEN-1:0] s2,
                                                     input logic [`XLEN-1:0] imm);
        return is_store_op(op) ? s1 + imm : s1 + s2;
    endfunction

    function automatic sram_sel_e ref_sel(input mem_op_e op, input logic [`XLEN-1:0] sum);
        logic [1:0] ram;
        ram = sum[`SRAM_TYPE_RNG];
        if (ram == 2'b11 || op == MEM_NONE) begin
            return SEL_NONE;
        end
        if (is_load_op(op)) begin
            return (ram == 2'b00) ? SEL_LD_IRAM : (ram == 2'b10) ? SEL_LD_WRAM : SEL_LD_ORAM;
        end
        return (ram == 2'b00) ? SEL_ST_IRAM : (ram == 2'b10) ? SEL_ST_WRAM : SEL_ST_ORAM;
    endfunction

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input sram_sel_e exp, input sram_sel_e act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s expected=%s actual=%s(%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    task automatic check_mem_op(input string name, input mem_op_e exp, input mem_op_e act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s expected=%s actual=%s(%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    // compare on every rising edge, then advance the expected state
    always @(posedge clk) begin : compare_proc
        logic             fire_exp;
        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] target;
        if (!rst_n) begin
            m_br_vld = 1'b0;
            m_lsu_vld = 1'b0;
            m_lsu_wb_vld = 1'b0;
        end else begin
            fire_exp = idu_alu_vld & lsu_alu_rdy & ~m_br_vld;
            sum = ref_mem_sum(idu_alu_mem_op, idu_alu_src1, idu_alu_src2, idu_alu_br_st_imm);
            if (idu_alu_vld && m_br_vld && idu_alu_wb_vld) flush_cnt++;
            if (idu_alu_vld && m_lsu_vld && !lsu_alu_rdy) stall_cnt++;

            check_bit("alu_idu_rdy", lsu_alu_rdy, alu_idu_rdy);
            check_bit("alu_idu_flush_vld", m_br_vld, alu_idu_flush_vld);
            check_bit("alu_idu_wb_vld", fire_exp & idu_alu_wb_vld, alu_idu_wb_vld);
            check_bit("alu_idu_ld_vld", is_load_op(idu_alu_mem_op), alu_idu_ld_vld);
            check_word("alu_idu_wb_addr", `XLEN'(idu_alu_wb_addr), `XLEN'(alu_idu_wb_addr));
            check_word("alu_idu_wb_data", ref_alu(idu_alu_alu_op, idu_alu_src1, idu_alu_src2,
                       idu_alu_pc), alu_idu_wb_data);

            check_bit("alu_ifu_br_vld", m_br_vld, alu_ifu_br_vld);
            if (m_br_vld) begin
                check_word("alu_ifu_br_addr", `XLEN'(m_br_addr), `XLEN'(alu_ifu_br_addr));
            end
            check_bit("alu_lsu_vld", m_lsu_vld, alu_lsu_vld);
            check_bit("alu_lsu_wb_vld", m_lsu_wb_vld, alu_lsu_wb_vld);
            if (m_lsu_vld) begin
                check_mem_op("alu_lsu_mem_op", m_mem_op, alu_lsu_mem_op);
                check_word("alu_lsu_wb_addr", `XLEN'(m_wb_addr), `XLEN'(alu_lsu_wb_addr));
                check_word("alu_lsu_wb_data", m_wb_data, alu_lsu_wb_data);
                check_word("alu_lsu_src2", m_src2, alu_lsu_src2);
                check_word("alu_lsu_ld_st_addr", `XLEN'(m_addr), `XLEN'(alu_lsu_ld_st_addr));
                check_sel("alu_lsu_sram_sel", m_sel, alu_lsu_sram_sel);
            end

            m_br_vld = fire_exp & ref_taken(idu_alu_br_op, idu_alu_src1, idu_alu_src2);
            if (m_br_vld) redirect_cnt++;
            m_lsu_vld = (fire_exp & ~is_cond_op(idu_alu_br_op)) | (m_lsu_vld & ~lsu_alu_rdy);
            m_lsu_wb_vld = (fire_exp & ~is_cond_op(idu_alu_br_op) & idu_alu_wb_vld)
                         | (m_lsu_wb_vld & ~lsu_alu_rdy);
            if (fire_exp) begin
                target = ref_target(idu_alu_br_op, idu_alu_src1, idu_alu_src2, idu_alu_pc,
                                    idu_alu_br_st_imm);
                m_br_addr = target[`BR_ADDR_W-1:0];
                m_mem_op = idu_alu_mem_op;
                m_wb_addr = idu_alu_wb_addr;
                m_wb_data = ref_alu(idu_alu_alu_op, idu_alu_src1, idu_alu_src2, idu_alu_pc);
                m_src2 = idu_alu_src2;
                m_addr = (is_load_op(idu_alu_mem_op) || is_store_op(idu_alu_mem_op))
                       ? sum[`SRAM_ADDR_RNG] : '0;
                m_sel = ref_sel(idu_alu_mem_op, sum);
            end
        end
    end

    task automatic drive_instr(input alu_op_e a, input br_op_e b, input mem_op_e m,
                               input logic [`XLEN-1:0] s1, input logic [`XLEN-1:0] s2,
                               input logic [`XLEN-1:0] imm, input logic rdy);
        logic [31:0] r;
        r = next_rand();
        @(negedge clk);
        idu_alu_vld = 1'b1;
        idu_alu_alu_op = a;
        idu_alu_br_op = b;
        idu_alu_mem_op = m;
        idu_alu_src1 = s1;
        idu_alu_src2 = s2;
        idu_alu_br_st_imm = imm;
        idu_alu_wb_vld = r[0];
        idu_alu_wb_addr = r[8:4];
        idu_alu_pc = next_rand() & 32'hffff_fffc;
        lsu_alu_rdy = rdy;
    endtask

    task automatic drive_random(input logic rdy);
        logic [31:0] r;
        r = next_rand();
        drive_instr(alu_op_e'(4'(r % 14)), br_op_e'(4'((r >> 8) % 9)),
                    mem_op_e'(4'((r >> 16) % 9)), next_rand(), next_rand(), next_rand(), rdy);
    endtask

    initial begin : main_proc
        logic [`XLEN-1:0] s1;
        logic [`XLEN-1:0] s2;
        logic [`XLEN-1:0] lo;
        logic [`XLEN-1:0] imm;
        int               n;
        rst_n = 1'b0;
        idu_alu_vld = 1'b0;
        idu_alu_src1 = '0;
        idu_alu_src2 = '0;
        idu_alu_br_st_imm = '0;
        idu_alu_pc = '0;
        idu_alu_wb_vld = 1'b0;
        idu_alu_wb_addr = '0;
        idu_alu_alu_op = ALU_NONE;
        idu_alu_br_op = BR_NONE;
        idu_alu_mem_op = MEM_NONE;
        lsu_alu_rdy = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_bit("alu_lsu_vld", 1'b0, alu_lsu_vld);
        check_bit("alu_lsu_wb_vld", 1'b0, alu_lsu_wb_vld);
        check_bit("alu_ifu_br_vld", 1'b0, alu_ifu_br_vld);

        // every alu op, some with the sign bit forced
        for (int op = 0; op < 14; op++) begin
            for (int i = 0; i < 6; i++) begin
                s1 = next_rand();
                s2 = next_rand();
                if (i % 3 != 0) s1[`XLEN-1] = 1'b1;
                if (i % 3 == 2) s2[`XLEN-1] = 1'b1;
                drive_instr(alu_op_e'(4'(op)), BR_NONE, MEM_NONE, s1, s2, next_rand(), 1'b1);
            end
        end

        // branches and jumps, equal operands on even passes
        for (int op = 1; op < 9; op++) begin
            for (int i = 0; i < 6; i++) begin
                s1 = next_rand();
                s2 = (i % 2 == 0) ? s1 : next_rand();
                if (i == 3) s1[`XLEN-1] = ~s2[`XLEN-1];
                drive_instr(op >= 7 ? ALU_LINK : ALU_NONE, br_op_e'(4'(op)), MEM_NONE,
                            s1, s2, next_rand(), 1'b1);
            end
        end

        // type field walks 00, 10, 01, 11 without carry from the low bits
        for (int op = 1; op < 9; op++) begin
            for (int i = 0; i < 8; i++) begin
                s1 = next_rand() & 32'hffff_8fff;
                s1[`SRAM_TYPE_RNG] = (i % 4 == 0) ? 2'b00 : (i % 4 == 1) ? 2'b10
                                   : (i % 4 == 2) ? 2'b01 : 2'b11;
                lo = next_rand() & 32'h0000_0fff;
                s2 = is_store_op(mem_op_e'(4'(op))) ? next_rand() : lo;
                imm = is_store_op(mem_op_e'(4'(op))) ? lo : next_rand();
                drive_instr(ALU_ADD, BR_NONE, mem_op_e'(4'(op)), s1, s2, imm, 1'b1);
            end
        end

        // back-pressure after a fired instruction, every other one a jal
        for (int k = 0; k < 12; k++) begin
            if (k % 2 == 0) begin
                drive_instr(ALU_LINK, BR_JAL, MEM_SW, next_rand(), next_rand(), next_rand(),
                            1'b1);
            end else begin
                drive_random(1'b1);
            end
            n = 1 + int'(next_rand() % 6);
            for (int j = 0; j < n; j++) begin
                drive_random(1'b0);
            end
        end

        @(negedge clk);
        idu_alu_vld = 1'b0;
        lsu_alu_rdy = 1'b1;
        repeat (3) @(negedge clk);

        if (flush_cnt == 0) begin
            other_cnt++;
            $display("ERROR: no write-back instruction was presented during a flush cycle");
        end
        if (stall_cnt == 0 || redirect_cnt == 0) begin
            other_cnt++;
            $display("ERROR: stall or redirect cases were never exercised");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog_proc
        #((NUM_TXN * 20 + 100) * CLK_PERIOD);
        $display("ERROR: simulation timed out before all tests finished");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
exe_pkg.sv
int_alu.sv
branch_unit.sv
mem_addr_gen.sv
lsu_issue_reg.sv
exe_top.sv
tb_exe_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exe_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "Verification failed" $(LOG); then exit 1; fi; exit $$rc

clean:
	rm -rf $(BUILD_DIR) $(LOG)
